/* run_sim.sh */
#!/bin/sh
# build the syndrome testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_syndrome \
    -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_syndrome" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if [ ! -s "$LOG" ]; then
    echo "simulation log is empty"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

/* syn_config.svh */
`ifndef SYN_CONFIG_SVH
`define SYN_CONFIG_SVH

// BCH (255,239) syndrome settings, GF(2^8)

`define SYN_M       8      // bits per field element
`define SYN_BEAT_W  8      // bits per input beat
`define SYN_BEATS   32     // beats per 256-bit frame
`define SYN_POLY    'h11D  // x^8+x^4+x^3+x^2+1

`endif

/* syn_even_sq.sv */
`include "syn_config.svh"

module syn_even_sq (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  syn_pkg::gf_elem_t i_s1,
    output syn_pkg::gf_elem_t o_s2,
    output syn_pkg::gf_elem_t o_s4
);

    syn_pkg::gf_elem_t s2_q;
    syn_pkg::gf_elem_t s4_q;
    syn_pkg::gf_elem_t s2_d;
    syn_pkg::gf_elem_t s4_d;

    // binary code, so S2 = S1^2 and S4 = S2^2
    assign s2_d = syn_pkg::gf_sq(i_s1);
    assign s4_d = syn_pkg::gf_sq(s2_q);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            s2_q <= '0;
            s4_q <= '0;
        end else begin
            s2_q <= s2_d;     // free running, tracks S1
            s4_q <= s4_d;     // one stage behind S2
        end
    end

    assign o_s2 = s2_q;
    assign o_s4 = s4_q;

    a_s2_square: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $past(i_rst_n) |-> (s2_q == syn_pkg::gf_sq($past(i_s1)))
    ) else $error("S2 is not the square of the previous S1");

endmodule

/* syn_frame_ctrl.sv */
`include "syn_config.svh"

module syn_frame_ctrl (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_clear,
    input  logic i_valid,
    output logic o_ready,
    output logic o_take,
    output logic o_clear,
    output logic o_odd_valid,
    output logic o_all_valid
);

    localparam syn_pkg::beat_cnt_t FRAME_BEATS = syn_pkg::beat_cnt_t'(`SYN_BEATS);

    syn_pkg::beat_cnt_t cnt_q;      // beats taken in current frame
    logic               full;
    logic [1:0]         done_dly_q; // matches the two squaring stages

    assign full        = (cnt_q == FRAME_BEATS);
    assign o_ready     = (cnt_q < FRAME_BEATS);
    assign o_take      = i_valid && o_ready && !i_clear; // clear wins
    assign o_clear     = i_clear;
    assign o_odd_valid = full;          // S1/S3 settle with the last take
    assign o_all_valid = done_dly_q[1];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (i_clear) begin
            cnt_q <= '0;
        end else if (o_take) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // S2 needs one more cycle after S1, S4 one more after S2
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            done_dly_q <= '0;
        end else if (i_clear) begin
            done_dly_q <= '0;
        end else begin
            done_dly_q <= {done_dly_q[0], full};
        end
    end

    a_cnt_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        cnt_q <= FRAME_BEATS
    ) else $error("beat counter past frame length");

    // the last beat of a frame closes the input on the next cycle
    a_take_ready: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_take && (cnt_q == (FRAME_BEATS - 1'b1))) |=> (!o_ready && !o_take)
    ) else $error("beat taken after the frame was full");

    // all-valid comes two cycles after odd-valid and drops with it
    a_all_odd: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_all_valid |-> (o_odd_valid && $past(o_odd_valid, 2))
    ) else $error("all_valid without odd_valid");

endmodule

/* syn_odd_acc.sv */
`include "syn_config.svh"

module syn_odd_acc #(
    parameter int unsigned SYN_INDEX = 1    // odd syndrome index j
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_clear,
    input  logic              i_take,
    input  syn_pkg::beat_t    i_data,
    output syn_pkg::gf_elem_t o_syn
);

    typedef syn_pkg::gf_elem_t [`SYN_BEAT_W-1:0] bit_pow_t;

    // alpha^(j*b) for each bit position, bit 0 is lowest degree
    function automatic bit_pow_t bit_pow_table();
        bit_pow_t t;
        for (int b = 0; b < `SYN_BEAT_W; b++) begin
            t[b] = syn_pkg::gf_alpha_pow(SYN_INDEX * b);
        end
        return t;
    endfunction

    localparam syn_pkg::gf_elem_t STEP    = syn_pkg::gf_alpha_pow(`SYN_BEAT_W * SYN_INDEX);
    localparam bit_pow_t          BIT_POW = bit_pow_table();

    syn_pkg::gf_elem_t syn_q;
    syn_pkg::gf_elem_t beat_sum;    // current beat evaluated at alpha^j
    syn_pkg::gf_elem_t horner;

    always_comb begin
        beat_sum = '0;
        for (int b = 0; b < `SYN_BEAT_W; b++) begin
            if (i_data[b]) begin
                beat_sum = beat_sum ^ BIT_POW[b];
            end
        end
    end

    // shift the partial result up by one beat, then add the new beat
    assign horner = syn_pkg::gf_mul(syn_q, STEP) ^ beat_sum;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            syn_q <= '0;
        end else if (i_clear) begin
            syn_q <= '0;
        end else if (i_take) begin
            syn_q <= horner;
        end
    end

    assign o_syn = syn_q;

    a_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (!i_take && !i_clear) |=> $stable(syn_q)
    ) else $error("syndrome S%0d moved without a take", SYN_INDEX);

endmodule

/* syn_pkg.sv */
`include "syn_config.svh"

package syn_pkg;

    typedef logic [`SYN_M-1:0] gf_elem_t;
    typedef logic [`SYN_BEAT_W-1:0] beat_t;                  // msb arrives first
    typedef logic [$clog2(`SYN_BEATS+1)-1:0] beat_cnt_t;    // holds 0..SYN_BEATS

    // multiply by alpha, reduce by the field polynomial
    function automatic gf_elem_t gf_xtime(input gf_elem_t a);
        gf_elem_t r;
        r = {a[`SYN_M-2:0], 1'b0};
        if (a[`SYN_M-1]) begin
            r = r ^ gf_elem_t'(`SYN_POLY);    // x^8 term drops out
        end
        return r;
    endfunction

    // shift-and-add product modulo SYN_POLY
    function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
        gf_elem_t acc;
        gf_elem_t sh;
        acc = '0;
        sh = a;
        for (int i = 0; i < `SYN_M; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = gf_xtime(sh);
        end
        return acc;
    endfunction

    function automatic gf_elem_t gf_sq(input gf_elem_t a);
        return gf_mul(a, a);
    endfunction

    // alpha^e, exponent folded into the multiplicative group order
    function automatic gf_elem_t gf_alpha_pow(input int unsigned e);
        gf_elem_t r;
        int unsigned n;
        r = gf_elem_t'(1);
        n = e % ((1 << `SYN_M) - 1);
        for (int unsigned k = 0; k < n; k++) begin
            r = gf_xtime(r);
        end
        return r;
    endfunction

endpackage

/* syndrome_top.sv */
`include "syn_config.svh"

module syndrome_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_clear,
    input  logic              i_valid,
    input  syn_pkg::beat_t    i_data,
    output logic              o_ready,
    output syn_pkg::gf_elem_t o_s1,
    output syn_pkg::gf_elem_t o_s2,
    output syn_pkg::gf_elem_t o_s3,
    output syn_pkg::gf_elem_t o_s4,
    output logic              o_odd_valid,
    output logic              o_all_valid
);

    logic take;         // beat accepted this cycle
    logic clear;

    syn_frame_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_clear     (i_clear),
        .i_valid     (i_valid),
        .o_ready     (o_ready),
        .o_take      (take),
        .o_clear     (clear),
        .o_odd_valid (o_odd_valid),
        .o_all_valid (o_all_valid)
    );

    syn_odd_acc #(
        .SYN_INDEX (1)
    ) u_s1 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (clear),
        .i_take  (take),
        .i_data  (i_data),
        .o_syn   (o_s1)
    );

    syn_odd_acc #(
        .SYN_INDEX (3)
    ) u_s3 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (clear),
        .i_take  (take),
        .i_data  (i_data),
        .o_syn   (o_s3)
    );

    // even syndromes follow S1 with no clear of their own
    syn_even_sq u_even (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_s1    (o_s1),
        .o_s2    (o_s2),
        .o_s4    (o_s4)
    );

endmodule

/* tb_syndrome.sv */
`include "syn_config.svh"

module tb_syndrome;

    localparam int FRAME_BITS = `SYN_BEATS * `SYN_BEAT_W;
    localparam int N_RANDOM   = 20;
    localparam int N_FRAMES   = N_RANDOM + 3;  // zero, random, gapped, after clear
    localparam int WAIT_LIMIT = 200;           // cycles per wait

    logic       i_clk;
    logic       i_rst_n;
    logic       i_clear;
    logic       i_valid;
    logic [7:0] i_data;
    logic       o_ready;
    logic [7:0] o_s1;
    logic [7:0] o_s2;
    logic [7:0] o_s3;
    logic [7:0] o_s4;
    logic       o_odd_valid;
    logic       o_all_valid;

    logic [FRAME_BITS-1:0] frame;      // bit FRAME_BITS-1 goes first
    logic [31:0]           exp_syn;    // {S4, S3, S2, S1}
    logic                  all_seen;
    int                    frames_checked = 0;

    syndrome_top uut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_clear     (i_clear),
        .i_valid     (i_valid),
        .i_data      (i_data),
        .o_ready     (o_ready),
        .o_s1        (o_s1),
        .o_s2        (o_s2),
        .o_s3        (o_s3),
        .o_s4        (o_s4),
        .o_odd_valid (o_odd_valid),
        .o_all_valid (o_all_valid)
    );

    always #5 i_clk = ~i_clk;

    // x * alpha, reduced by x^8+x^4+x^3+x^2+1
    function automatic logic [7:0] times_alpha(input logic [7:0] a);
        logic [8:0] t;
        t = {a, 1'b0};
        if (t[8]) begin
            t = t ^ 9'h11D;
        end
        return t[7:0];
    endfunction

    // received polynomial at alpha^j, j = 1..4, first bit is the top degree
    function automatic logic [31:0] ref_syndromes(input logic [FRAME_BITS-1:0] f);
        logic [7:0]  acc;
        logic [31:0] r;
        r = '0;
        for (int j = 1; j <= 4; j++) begin
            acc = '0;
            for (int i = FRAME_BITS - 1; i >= 0; i--) begin
                for (int k = 0; k < j; k++) begin
                    acc = times_alpha(acc);    // acc * alpha^j
                end
                acc[0] = acc[0] ^ f[i];
            end
            r[8*(j-1) +: 8] = acc;
        end
        return r;
    endfunction

    task automatic end_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_value(input string name, input logic [7:0] exp,
                                 input logic [7:0] act);
        if (act !== exp) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_syndromes(input logic [31:0] exp);
        compare_value("o_s1", exp[7:0], o_s1);
        compare_value("o_s2", exp[15:8], o_s2);
        compare_value("o_s3", exp[23:16], o_s3);
        compare_value("o_s4", exp[31:24], o_s4);
    endtask

    task automatic check_flags(input logic ready, input logic odd, input logic all);
        compare_value("o_ready", 8'(ready), 8'(o_ready));
        compare_value("o_odd_valid", 8'(odd), 8'(o_odd_valid));
        compare_value("o_all_valid", 8'(all), 8'(o_all_valid));
    endtask

    task automatic make_random_frame(output logic [FRAME_BITS-1:0] f);
        for (int k = 0; k < FRAME_BITS / 32; k++) begin
            f[32*k +: 32] = $urandom;
        end
        f[FRAME_BITS-1] = 1'b0;    // leading pad bit
    endtask

    // offer one beat, return just after the edge that takes it
    task automatic send_beat(input logic [7:0] b, input bit gaps);
        int idle;
        int waited;
        idle = gaps ? int'($urandom % 4) : 0;
        repeat (idle) begin
            i_valid <= 1'b0;
            i_data  <= 8'($urandom);   // junk while idle
            @(posedge i_clk);
        end
        i_valid <= 1'b1;
        i_data  <= b;
        waited = 0;
        @(negedge i_clk);
        while (!o_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Error at %0t: o_ready stayed low, beat was never taken", $time);
                end_with_failure();
            end
            @(negedge i_clk);
        end
        compare_value("o_odd_valid", 8'd0, 8'(o_odd_valid));  // frame still open
        @(posedge i_clk);
    endtask

    task automatic send_beats(input logic [FRAME_BITS-1:0] f, input int count,
                              input bit gaps);
        for (int k = 0; k < count; k++) begin
            send_beat(f[FRAME_BITS-1-8*k -: 8], gaps);
        end
        i_valid <= 1'b0;
    endtask

    // called right after the edge that took the last beat
    task automatic check_flag_spacing(input logic [31:0] exp);
        @(negedge i_clk);
        check_flags(1'b0, 1'b1, 1'b0);
        compare_value("o_s1", exp[7:0], o_s1);
        compare_value("o_s3", exp[23:16], o_s3);
        @(negedge i_clk);
        check_flags(1'b0, 1'b1, 1'b0);
        @(negedge i_clk);
        check_flags(1'b0, 1'b1, 1'b1);     // two cycles after odd
        @(posedge i_clk);
    endtask

    task automatic wait_all_valid();
        int waited;
        waited = 0;
        @(negedge i_clk);
        while (!o_all_valid) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Error at %0t: o_all_valid never came up", $time);
                end_with_failure();
            end
            @(negedge i_clk);
        end
        @(posedge i_clk);
    endtask

    task automatic clear_frame(input bit with_valid);
        i_clear <= 1'b1;
        if (with_valid) begin
            i_valid <= 1'b1;
            i_data  <= 8'hFF;    // must lose against the clear
        end
        @(posedge i_clk);
        i_clear <= 1'b0;
        i_valid <= 1'b0;
        @(negedge i_clk);
        check_flags(1'b1, 1'b0, 1'b0);
        compare_value("o_s1", 8'd0, o_s1);
        compare_value("o_s3", 8'd0, o_s3);
        @(posedge i_clk);
    endtask

    // compare all four syndromes whenever all-valid rises
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            all_seen = 1'b0;
        end else begin
            if (o_all_valid && !all_seen) begin
                check_syndromes(exp_syn);
                frames_checked = frames_checked + 1;
            end
            all_seen = o_all_valid;
        end
    end

    initial begin
        void'($urandom(4184));
        i_clk   = 1'b0;
        i_rst_n <= 1'b0;
        i_clear <= 1'b0;
        i_valid <= 1'b0;
        i_data  <= '0;
        exp_syn = '0;
        frame   = '0;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;

        @(negedge i_clk);
        check_flags(1'b1, 1'b0, 1'b0);
        check_syndromes(32'd0);
        @(posedge i_clk);

        // all-zero frame
        exp_syn = ref_syndromes(frame);
        send_beats(frame, `SYN_BEATS, 1'b0);
        check_flag_spacing(exp_syn);
        clear_frame(1'b0);

        for (int n = 0; n < N_RANDOM; n++) begin
            make_random_frame(frame);
            exp_syn = ref_syndromes(frame);
            send_beats(frame, `SYN_BEATS, 1'b0);
            check_flag_spacing(exp_syn);
            clear_frame(1'b0);
        end

        // random holes in valid
        make_random_frame(frame);
        exp_syn = ref_syndromes(frame);
        send_beats(frame, `SYN_BEATS, 1'b1);
        wait_all_valid();

        // extra beats against a full frame
        repeat (6) begin
            i_valid <= 1'b1;
            i_data  <= 8'($urandom);
            @(negedge i_clk);
            check_flags(1'b0, 1'b1, 1'b1);
            check_syndromes(exp_syn);
            @(posedge i_clk);
        end
        i_valid <= 1'b0;
        clear_frame(1'b0);

        // abandon a frame after 10 beats, then a fresh one
        make_random_frame(frame);
        send_beats(frame, 10, 1'b0);
        clear_frame(1'b1);
        make_random_frame(frame);
        exp_syn = ref_syndromes(frame);
        send_beats(frame, `SYN_BEATS, 1'b0);
        wait_all_valid();

        if (frames_checked != N_FRAMES) begin
            $display("Error: only %0d of %0d frames reached all-valid",
                     frames_checked, N_FRAMES);
            end_with_failure();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+.
syn_pkg.sv
syn_frame_ctrl.sv
syn_odd_acc.sv
syn_even_sq.sv
syndrome_top.sv
tb_syndrome.sv
